// ==== flist.f ====
+incdir+hw
hw/mem_access_pkg.sv
hw/stq_pkg.sv
hw/stq_entry_if.sv
hw/stq_store_decode.sv
hw/stq_entry_array.sv
hw/stq_fwd_check.sv
hw/stq_drain_apb.sv
hw/stq_top.sv
test/tb_clk_gen.sv
test/tb_stq.sv

// ==== hw/mem_access_pkg.sv ====
`include "stq_cfg_macros.svh"

package mem_access_pkg;

  typedef logic [`STQ_PADDR_W-1:0]       paddr_t;
  typedef logic [`STQ_PADDR_W-4:0]       dw_addr_t;   // Address without byte offset
  typedef logic [`STQ_ST_DATA_W-1:0]     st_data_t;
  typedef logic [`STQ_LINE_DATA_W-1:0]   lane_data_t;
  typedef logic [`STQ_LINE_DATA_W/8-1:0] byte_en_t;   // One bit per byte lane

  typedef enum logic [1:0] {
    SIZE_B = 2'd0,
    SIZE_H = 2'd1,
    SIZE_W = 2'd2
  } mem_size_e;

  // Size mask moved up to the byte offset inside the doubleword
  function automatic byte_en_t gen_byte_en(mem_size_e size, logic [2:0] offset);
    byte_en_t mask;
    case (size)
      SIZE_B:  mask = byte_en_t'(8'h01);
      SIZE_H:  mask = byte_en_t'(8'h03);
      SIZE_W:  mask = byte_en_t'(8'h0f);
      default: mask = '0;
    endcase
    return mask << offset;
  endfunction

endpackage

// ==== hw/stq_cfg_macros.svh ====
`ifndef STQ_CFG_MACROS_SVH
`define STQ_CFG_MACROS_SVH

// ====================
// Queue sizing
// ====================

// Number of store queue entries
`define STQ_DEPTH 8

// ====================
// Datapath widths
// ====================

`define STQ_PADDR_W 32     // Physical address
`define STQ_ST_DATA_W 32   // Raw store data from execute
`define STQ_LINE_DATA_W 64 // Memory write port

`endif

// ==== hw/stq_drain_apb.sv ====
`timescale 1ns/1ps

module stq_drain_apb (
  input  logic                       i_clk,
  input  logic                       i_reset_n,
  input  logic                       i_pready,
  stq_entry_if.consumer              ent,
  output logic                       o_entry_free,
  output logic                       o_psel,
  output logic                       o_penable,
  output mem_access_pkg::paddr_t     o_paddr,
  output mem_access_pkg::lane_data_t o_pwdata,
  output mem_access_pkg::byte_en_t   o_pstrb
);

  typedef enum logic [1:0] {
    APB_IDLE   = 2'd0,
    APB_SETUP  = 2'd1,
    APB_ACCESS = 2'd2
  } apb_state_e;

  apb_state_e        r_state;
  stq_pkg::stq_idx_t w_head_idx;
  stq_pkg::stq_idx_t w_next_idx;
  logic              w_start;

  assign o_entry_free = (r_state == APB_ACCESS) && i_pready;
  assign o_psel       = (r_state != APB_IDLE);
  assign o_penable    = (r_state == APB_ACCESS);

  // Back-to-back transfers look one entry ahead
  assign w_head_idx = stq_pkg::stq_idx_t'(ent.head_ptr);
  assign w_next_idx = o_entry_free ? w_head_idx + 1'b1 : w_head_idx;
  assign w_start    = ((r_state == APB_IDLE) || o_entry_free) &&
                      (ent.state[w_next_idx] == stq_pkg::STQ_COMMIT);

  // ====================
  // APB write FSM
  // ====================
  always_ff @(posedge i_clk or negedge i_reset_n) begin
    if (!i_reset_n) begin
      r_state <= APB_IDLE;
    end else begin
      case (r_state)
        APB_IDLE:   if (w_start) r_state <= APB_SETUP;
        APB_SETUP:  r_state <= APB_ACCESS;
        APB_ACCESS: begin
          if (i_pready) r_state <= w_start ? APB_SETUP : APB_IDLE;
        end
        default:    r_state <= APB_IDLE;
      endcase
    end
  end

  // Capture the head entry as the setup phase opens
  always_ff @(posedge i_clk) begin
    if (w_start) begin
      o_paddr  <= {ent.dw_addr[w_next_idx], 3'b000};
      o_pwdata <= ent.lane_data[w_next_idx];
      o_pstrb  <= ent.byte_en[w_next_idx];
    end
  end

  a_apb_hold: assert property (@(posedge i_clk) disable iff (!i_reset_n)
    (o_penable && !i_pready) |=> (o_psel && o_penable && $stable(o_paddr) &&
                                  $stable(o_pwdata) && $stable(o_pstrb)))
    else $error("APB outputs changed while waiting for PREADY");

endmodule

// ==== hw/stq_entry_array.sv ====
`timescale 1ns/1ps
`include "stq_cfg_macros.svh"

module stq_entry_array (
  input  logic                       i_clk,
  input  logic                       i_reset_n,
  input  logic                       i_disp_valid,
  output logic                       o_disp_ready,
  output stq_pkg::stq_ptr_t          o_disp_idx,
  input  logic                       i_addr_valid,
  input  stq_pkg::stq_idx_t          i_addr_idx,
  input  mem_access_pkg::dw_addr_t   i_dw_addr,
  input  mem_access_pkg::byte_en_t   i_byte_en,
  input  logic                       i_data_valid,
  input  stq_pkg::stq_idx_t          i_data_idx,
  input  mem_access_pkg::lane_data_t i_lane_data,
  input  logic                       i_commit_valid,
  input  logic                       i_entry_free,
  stq_entry_if.producer              ent
);

  stq_pkg::stq_ptr_t r_cmt_ptr;   // Oldest entry not yet committed
  stq_pkg::stq_idx_t w_tail_idx;
  stq_pkg::stq_idx_t w_cmt_idx;
  stq_pkg::stq_idx_t w_head_idx;
  stq_pkg::stq_idx_t w_next_head_idx;
  logic              w_full;
  logic              w_alloc;
  logic              w_drain_start;

  assign w_tail_idx = stq_pkg::stq_idx_t'(ent.tail_ptr);
  assign w_cmt_idx  = stq_pkg::stq_idx_t'(r_cmt_ptr);
  assign w_head_idx = stq_pkg::stq_idx_t'(ent.head_ptr);

  // Same index, opposite wrap bit
  assign w_full = (w_tail_idx == w_head_idx) &&
                  (ent.tail_ptr[stq_pkg::STQ_IDX_W] != ent.head_ptr[stq_pkg::STQ_IDX_W]);
  assign o_disp_ready = !w_full;
  assign o_disp_idx   = ent.tail_ptr;
  assign w_alloc      = i_disp_valid && !w_full;

  // Drain picks up the entry after the one being freed
  assign w_next_head_idx = i_entry_free ? w_head_idx + 1'b1 : w_head_idx;
  assign w_drain_start   = (ent.state[w_next_head_idx] == stq_pkg::STQ_COMMIT);

  // ====================
  // Pointers and entry FSM
  // ====================
  always_ff @(posedge i_clk or negedge i_reset_n) begin
    if (!i_reset_n) begin
      ent.tail_ptr   <= '0;
      ent.head_ptr   <= '0;
      r_cmt_ptr      <= '0;
      ent.addr_known <= '0;
      ent.data_known <= '0;
      for (int i = 0; i < `STQ_DEPTH; i++) begin
        ent.state[i] <= stq_pkg::STQ_FREE;
      end
    end else begin
      ent.tail_ptr <= ent.tail_ptr + w_alloc;
      ent.head_ptr <= ent.head_ptr + i_entry_free;
      r_cmt_ptr    <= r_cmt_ptr + i_commit_valid;
      for (int i = 0; i < `STQ_DEPTH; i++) begin
        if (w_alloc && (w_tail_idx == i)) begin
          ent.addr_known[i] <= 1'b0;
          ent.data_known[i] <= 1'b0;
        end
        if (i_addr_valid && (i_addr_idx == i)) ent.addr_known[i] <= 1'b1;
        if (i_data_valid && (i_data_idx == i)) ent.data_known[i] <= 1'b1;

        case (ent.state[i])
          stq_pkg::STQ_FREE: begin
            if (w_alloc && (w_tail_idx == i)) ent.state[i] <= stq_pkg::STQ_WAIT;
          end
          stq_pkg::STQ_WAIT: begin
            if (ent.addr_known[i] && ent.data_known[i]) ent.state[i] <= stq_pkg::STQ_READY;
          end
          stq_pkg::STQ_READY: begin
            if (i_commit_valid && (w_cmt_idx == i)) ent.state[i] <= stq_pkg::STQ_COMMIT;
          end
          stq_pkg::STQ_COMMIT: begin
            if (w_drain_start && (w_next_head_idx == i)) ent.state[i] <= stq_pkg::STQ_DRAIN;
          end
          stq_pkg::STQ_DRAIN: begin
            if (i_entry_free && (w_head_idx == i)) ent.state[i] <= stq_pkg::STQ_FREE;
          end
          default: ent.state[i] <= stq_pkg::STQ_FREE;
        endcase
      end
    end
  end

  // Payload
  always_ff @(posedge i_clk) begin
    if (i_addr_valid) begin
      ent.dw_addr[i_addr_idx] <= i_dw_addr;
      ent.byte_en[i_addr_idx] <= i_byte_en;
    end
    if (i_data_valid) ent.lane_data[i_data_idx] <= i_lane_data;
  end

  a_addr_upd_alloc: assert property (@(posedge i_clk) disable iff (!i_reset_n)
    i_addr_valid |-> (ent.state[i_addr_idx] != stq_pkg::STQ_FREE))
    else $error("Address update to free entry %0d", i_addr_idx);

  a_data_upd_alloc: assert property (@(posedge i_clk) disable iff (!i_reset_n)
    i_data_valid |-> (ent.state[i_data_idx] != stq_pkg::STQ_FREE))
    else $error("Data update to free entry %0d", i_data_idx);

  a_commit_ready: assert property (@(posedge i_clk) disable iff (!i_reset_n)
    i_commit_valid |-> (ent.state[w_cmt_idx] == stq_pkg::STQ_READY))
    else $error("Commit of entry %0d which is not READY", w_cmt_idx);

endmodule

// ==== hw/stq_entry_if.sv ====
`timescale 1ns/1ps
`include "stq_cfg_macros.svh"

interface stq_entry_if;

  // Per-entry state
  stq_pkg::stq_state_e       state      [`STQ_DEPTH];
  logic [`STQ_DEPTH-1:0]     addr_known;
  logic [`STQ_DEPTH-1:0]     data_known;
  mem_access_pkg::dw_addr_t  dw_addr    [`STQ_DEPTH];
  mem_access_pkg::byte_en_t  byte_en    [`STQ_DEPTH];
  mem_access_pkg::lane_data_t lane_data [`STQ_DEPTH];

  // Queue pointers
  stq_pkg::stq_ptr_t head_ptr; // Oldest occupied entry
  stq_pkg::stq_ptr_t tail_ptr; // Next entry to allocate

  modport producer (
    output state, addr_known, data_known,
    output dw_addr, byte_en, lane_data,
    output head_ptr, tail_ptr
  );

  modport consumer (
    input state, addr_known, data_known,
    input dw_addr, byte_en, lane_data,
    input head_ptr, tail_ptr
  );

endinterface

// ==== hw/stq_fwd_check.sv ====
`timescale 1ns/1ps
`include "stq_cfg_macros.svh"

module stq_fwd_check (
  input  logic                       i_clk,
  input  logic                       i_reset_n,
  input  logic                       i_ld_valid,
  input  mem_access_pkg::paddr_t     i_ld_paddr,
  input  mem_access_pkg::mem_size_e  i_ld_size,
  input  stq_pkg::stq_ptr_t          i_ld_stq_tail,
  stq_entry_if.consumer              ent,
  output logic                       o_fwd_valid,
  output logic                       o_fwd_hazard,
  output mem_access_pkg::byte_en_t   o_fwd_be,
  output mem_access_pkg::lane_data_t o_fwd_data
);

  mem_access_pkg::dw_addr_t   w_ld_dw;
  mem_access_pkg::byte_en_t   w_ld_be;
  stq_pkg::stq_ptr_t          w_ld_dist;   // Entries from head up to the load's tail
  stq_pkg::stq_ptr_t          w_ld_span;
  logic                       w_hazard;
  logic                       w_found;
  mem_access_pkg::byte_en_t   w_sel_be;
  mem_access_pkg::lane_data_t w_sel_data;

  assign w_ld_dw   = i_ld_paddr[`STQ_PADDR_W-1:3];
  assign w_ld_be   = mem_access_pkg::gen_byte_en(i_ld_size, i_ld_paddr[2:0]);
  assign w_ld_dist = i_ld_stq_tail - ent.head_ptr;
  // Load tail behind head means every older store has drained
  assign w_ld_span = (w_ld_dist > stq_pkg::stq_ptr_t'(`STQ_DEPTH)) ? '0 : w_ld_dist;

  // ====================
  // Older store search
  // ====================
  always_comb begin : search
    stq_pkg::stq_idx_t idx;
    logic              older;
    logic              hit;
    w_hazard   = 1'b0;
    w_found    = 1'b0;
    w_sel_be   = '0;
    w_sel_data = '0;
    // Youngest first, so the first hit wins
    for (int k = `STQ_DEPTH - 1; k >= 0; k--) begin
      idx   = stq_pkg::stq_idx_t'(ent.head_ptr) + stq_pkg::stq_idx_t'(k);
      older = (stq_pkg::stq_ptr_t'(k) < w_ld_span) && (ent.state[idx] != stq_pkg::STQ_FREE);
      hit   = ent.addr_known[idx] && (ent.dw_addr[idx] == w_ld_dw) &&
              |(ent.byte_en[idx] & w_ld_be);
      if (older && (!ent.addr_known[idx] || (hit && !ent.data_known[idx]))) begin
        w_hazard = 1'b1;
      end
      if (older && hit && !w_found) begin
        w_found    = 1'b1;
        w_sel_be   = ent.byte_en[idx] & w_ld_be;
        w_sel_data = ent.lane_data[idx];
      end
    end
  end

  always_ff @(posedge i_clk or negedge i_reset_n) begin
    if (!i_reset_n) begin
      o_fwd_valid  <= 1'b0;
      o_fwd_hazard <= 1'b0;
    end else begin
      o_fwd_valid  <= i_ld_valid && w_found && !w_hazard;
      o_fwd_hazard <= i_ld_valid && w_hazard;
    end
  end

  always_ff @(posedge i_clk) begin
    o_fwd_be   <= w_sel_be;
    o_fwd_data <= w_sel_data;
  end

  // Load's tail never runs ahead of the allocation pointer
  a_ld_tail_range: assert property (@(posedge i_clk) disable iff (!i_reset_n)
    i_ld_valid |-> ((ent.tail_ptr - i_ld_stq_tail) <= stq_pkg::stq_ptr_t'(`STQ_DEPTH)))
    else $error("Load tail %0d outside queue", i_ld_stq_tail);

endmodule

// ==== hw/stq_pkg.sv ====
`include "stq_cfg_macros.svh"

package stq_pkg;

  localparam int STQ_IDX_W = $clog2(`STQ_DEPTH);

  typedef logic [STQ_IDX_W-1:0] stq_idx_t;
  typedef logic [STQ_IDX_W:0]   stq_ptr_t;  // Top bit flips on each wrap

  // ====================
  // Entry life cycle
  // ====================
  typedef enum logic [2:0] {
    STQ_FREE   = 3'd0,
    STQ_WAIT   = 3'd1, // Allocated, address or data still missing
    STQ_READY  = 3'd2,
    STQ_COMMIT = 3'd3,
    STQ_DRAIN  = 3'd4  // APB write in flight
  } stq_state_e;

endpackage

// ==== hw/stq_store_decode.sv ====
`timescale 1ns/1ps

module stq_store_decode (
  input  logic                       i_addr_valid,
  input  stq_pkg::stq_idx_t          i_addr_idx,
  input  mem_access_pkg::paddr_t     i_addr_paddr,
  input  mem_access_pkg::mem_size_e  i_addr_size,
  input  logic                       i_data_valid,
  input  stq_pkg::stq_idx_t          i_data_idx,
  input  mem_access_pkg::st_data_t   i_data_value,
  input  mem_access_pkg::mem_size_e  i_data_size,
  output logic                       o_addr_valid,
  output stq_pkg::stq_idx_t          o_addr_idx,
  output mem_access_pkg::dw_addr_t   o_dw_addr,
  output mem_access_pkg::byte_en_t   o_byte_en,
  output logic                       o_data_valid,
  output stq_pkg::stq_idx_t          o_data_idx,
  output mem_access_pkg::lane_data_t o_lane_data
);

  assign o_addr_valid = i_addr_valid;
  assign o_addr_idx   = i_addr_idx;
  assign o_dw_addr    = i_addr_paddr[`STQ_PADDR_W-1:3];
  assign o_byte_en    = mem_access_pkg::gen_byte_en(i_addr_size, i_addr_paddr[2:0]);

  assign o_data_valid = i_data_valid;
  assign o_data_idx   = i_data_idx;

  // Repeat the stored bytes over every lane
  always_comb begin
    case (i_data_size)
      mem_access_pkg::SIZE_B: o_lane_data = {8{i_data_value[7:0]}};
      mem_access_pkg::SIZE_H: o_lane_data = {4{i_data_value[15:0]}};
      mem_access_pkg::SIZE_W: o_lane_data = {2{i_data_value[31:0]}};
      default:                o_lane_data = '0;
    endcase
  end

  // Half on odd byte or word off a 4-byte boundary
  always_comb begin
    if (i_addr_valid) begin
      a_addr_aligned: assert final (
        !((i_addr_size == mem_access_pkg::SIZE_H) && i_addr_paddr[0]) &&
        !((i_addr_size == mem_access_pkg::SIZE_W) && (i_addr_paddr[1:0] != 2'b00)))
        else $error("Misaligned store address %h", i_addr_paddr);
    end
  end

endmodule

// ==== hw/stq_top.sv ====
`timescale 1ns/1ps

module stq_top (
  input  logic                       i_clk,
  input  logic                       i_reset_n,
  // Dispatch
  input  logic                       i_disp_valid,
  output logic                       o_disp_ready,
  output stq_pkg::stq_ptr_t          o_disp_idx,
  // Address and data updates
  input  logic                       i_addr_valid,
  input  stq_pkg::stq_idx_t          i_addr_idx,
  input  mem_access_pkg::paddr_t     i_addr_paddr,
  input  mem_access_pkg::mem_size_e  i_addr_size,
  input  logic                       i_data_valid,
  input  stq_pkg::stq_idx_t          i_data_idx,
  input  mem_access_pkg::st_data_t   i_data_value,
  input  mem_access_pkg::mem_size_e  i_data_size,
  input  logic                       i_commit_valid,
  // Load check
  input  logic                       i_ld_valid,
  input  mem_access_pkg::paddr_t     i_ld_paddr,
  input  mem_access_pkg::mem_size_e  i_ld_size,
  input  stq_pkg::stq_ptr_t          i_ld_stq_tail,
  output logic                       o_fwd_valid,
  output logic                       o_fwd_hazard,
  output mem_access_pkg::byte_en_t   o_fwd_be,
  output mem_access_pkg::lane_data_t o_fwd_data,
  // APB write master
  output logic                       o_psel,
  output logic                       o_penable,
  output mem_access_pkg::paddr_t     o_paddr,
  output mem_access_pkg::lane_data_t o_pwdata,
  output mem_access_pkg::byte_en_t   o_pstrb,
  input  logic                       i_pready
);

  logic                       w_addr_valid;
  stq_pkg::stq_idx_t          w_addr_idx;
  mem_access_pkg::dw_addr_t   w_dw_addr;
  mem_access_pkg::byte_en_t   w_byte_en;
  logic                       w_data_valid;
  stq_pkg::stq_idx_t          w_data_idx;
  mem_access_pkg::lane_data_t w_lane_data;
  logic                       w_entry_free;

  stq_entry_if u_ent_if ();

  stq_store_decode u_decode (
    .i_addr_valid, .i_addr_idx, .i_addr_paddr, .i_addr_size,
    .i_data_valid, .i_data_idx, .i_data_value, .i_data_size,
    .o_addr_valid (w_addr_valid), .o_addr_idx (w_addr_idx),
    .o_dw_addr    (w_dw_addr),    .o_byte_en  (w_byte_en),
    .o_data_valid (w_data_valid), .o_data_idx (w_data_idx),
    .o_lane_data  (w_lane_data)
  );

  stq_entry_array u_array (
    .i_clk, .i_reset_n, .i_disp_valid, .o_disp_ready, .o_disp_idx,
    .i_addr_valid (w_addr_valid), .i_addr_idx (w_addr_idx),
    .i_dw_addr    (w_dw_addr),    .i_byte_en  (w_byte_en),
    .i_data_valid (w_data_valid), .i_data_idx (w_data_idx),
    .i_lane_data  (w_lane_data),
    .i_commit_valid, .i_entry_free (w_entry_free), .ent (u_ent_if.producer)
  );

  stq_fwd_check u_fwd (
    .i_clk, .i_reset_n, .i_ld_valid, .i_ld_paddr, .i_ld_size, .i_ld_stq_tail,
    .ent (u_ent_if.consumer),
    .o_fwd_valid, .o_fwd_hazard, .o_fwd_be, .o_fwd_data
  );

  stq_drain_apb u_drain (
    .i_clk, .i_reset_n, .i_pready, .ent (u_ent_if.consumer),
    .o_entry_free (w_entry_free),
    .o_psel, .o_penable, .o_paddr, .o_pwdata, .o_pstrb
  );

endmodule

// ==== test/tb_clk_gen.sv ====
`timescale 1ns/1ps

module tb_clk_gen #(
  parameter real PERIOD_NS    = 8.0,
  parameter int  RESET_CYCLES = 3
) (
  output logic o_clk,
  output logic o_reset_n
);

  initial begin
    o_clk = 1'b0;
    forever #(PERIOD_NS / 2.0) o_clk = ~o_clk;
  end

  initial begin
    o_reset_n = 1'b0;
    repeat (RESET_CYCLES) @(posedge o_clk);
    @(negedge o_clk); // Release away from the rising edge
    o_reset_n = 1'b1;
  end

endmodule

// ==== test/tb_stq.sv ====
`timescale 1ns/1ps

module tb_stq;

  localparam int NUM_STORES     = 40;
  localparam int TIMEOUT_CYCLES = 20 * NUM_STORES + 200;

  logic i_clk, i_reset_n, i_disp_valid, i_addr_valid, i_data_valid, i_commit_valid;
  logic i_ld_valid, i_pready, o_disp_ready, o_fwd_valid, o_fwd_hazard, o_psel, o_penable;
  logic [2:0]  i_addr_idx, i_data_idx;
  logic [31:0] i_addr_paddr, i_data_value, i_ld_paddr, o_paddr;
  logic [7:0]  o_fwd_be, o_pstrb;
  logic [63:0] o_fwd_data, o_pwdata;
  mem_access_pkg::mem_size_e i_addr_size, i_data_size, i_ld_size;
  stq_pkg::stq_ptr_t         i_ld_stq_tail, o_disp_idx;

  // Reference model of the queue, indexed by entry
  logic [31:0]               m_paddr [8];
  logic [31:0]               m_data  [8];
  mem_access_pkg::mem_size_e m_size  [8];
  logic [7:0]                m_ak, m_dk, m_rdy; // Address known, data known, READY
  stq_pkg::stq_ptr_t         m_head, m_tail, m_cmt;
  logic                      exp_ld, exp_hz, exp_fv, exp_psel, exp_pen;
  logic [7:0]                exp_be;
  logic [63:0]               exp_data;
  int                        errors, checks, cycles, sent;

  tb_clk_gen u_clk_gen (.o_clk(i_clk), .o_reset_n(i_reset_n));

  stq_top i_dut (.*);

  function automatic logic [7:0] strobe_of(mem_access_pkg::mem_size_e size, logic [2:0] off);
    return ((8'd1 << (1 << size)) - 8'd1) << off;
  endfunction

  function automatic logic [63:0] replicate(logic [31:0] data, mem_access_pkg::mem_size_e size);
    logic [63:0] lanes;
    for (int b = 0; b < 8; b++) begin
      lanes[8*b +: 8] = data[8*(b % (1 << size)) +: 8];
    end
    return lanes;
  endfunction

  // Four doublewords only, so loads hit stores often
  function automatic logic [31:0] rand_addr(mem_access_pkg::mem_size_e size);
    logic [2:0] off;
    off = 3'($urandom_range(7));
    off = off & ~((3'd1 << size) - 3'd1);
    return {29'h200 + 29'($urandom_range(3)), off};
  endfunction

  task automatic check_value(string name, logic [63:0] got, logic [63:0] exp);
    checks++;
    assert (got === exp) else begin
      errors++;
      $display("Mismatch at %0t: %s is %h, expected %h", $time, name, got, exp);
    end
  endtask

  // Youngest older store first
  task automatic predict_load();
    stq_pkg::stq_ptr_t occ, behind;
    logic [2:0]        idx;
    logic [7:0]        ovl;
    logic              match, found;
    int                n_older;
    occ = m_tail - m_head;
    behind = m_tail - i_ld_stq_tail;
    n_older = (behind >= occ) ? 0 : int'(occ - behind);
    found = 1'b0;
    exp_hz = 1'b0;
    for (int j = n_older - 1; j >= 0; j--) begin
      idx = m_head[2:0] + 3'(j);
      ovl = strobe_of(i_ld_size, i_ld_paddr[2:0]) & strobe_of(m_size[idx], m_paddr[idx][2:0]);
      match = (m_paddr[idx][31:3] == i_ld_paddr[31:3]) && (ovl != 0);
      if (!m_ak[idx] || (match && !m_dk[idx])) begin
        exp_hz = 1'b1;
      end else if (match && !found) begin
        found = 1'b1;
        exp_be = ovl;
        exp_data = replicate(m_data[idx], m_size[idx]);
      end
    end
    exp_fv = found && !exp_hz;
  endtask

  // DUT outputs after a rising edge against the model
  task automatic compare_outputs();
    stq_pkg::stq_ptr_t occ;
    logic [2:0]        hi;
    occ = m_tail - m_head;
    hi = m_head[2:0];
    check_value("o_fwd_hazard", o_fwd_hazard, exp_ld && exp_hz);
    check_value("o_fwd_valid", o_fwd_valid, exp_ld && exp_fv);
    if (exp_ld && exp_fv) begin
      check_value("o_fwd_be", o_fwd_be, exp_be);
      check_value("o_fwd_data", o_fwd_data, exp_data);
    end
    check_value("o_disp_ready", o_disp_ready, occ != 8);
    check_value("o_disp_idx", o_disp_idx, m_tail);
    check_value("o_psel", o_psel, exp_psel);
    check_value("o_penable", o_penable, exp_pen);
    if (o_psel) begin // Head entry is the one on the bus
      check_value("o_paddr", o_paddr, {m_paddr[hi][31:3], 3'b000});
      check_value("o_pwdata", o_pwdata, replicate(m_data[hi], m_size[hi]));
      check_value("o_pstrb", o_pstrb, strobe_of(m_size[hi], m_paddr[hi][2:0]));
    end
  endtask

  // ====================
  // One falling edge
  // ====================
  task automatic step();
    stq_pkg::stq_ptr_t occ, ncmt;
    logic [2:0]        hi, ti;
    logic              fill, free;
    int                r;
    occ = m_tail - m_head;
    ncmt = m_cmt - m_head;
    hi = m_head[2:0];
    compare_outputs();

    fill = (sent < 8); // First fill the queue with unresolved stores
    i_disp_valid = (sent < NUM_STORES) && (fill || $urandom_range(1));
    r = $urandom_range(7);
    i_addr_idx = hi + 3'(r);
    i_addr_valid = !fill && (r < occ) && !m_ak[i_addr_idx];
    i_addr_paddr = m_paddr[i_addr_idx];
    i_addr_size = m_size[i_addr_idx];
    r = $urandom_range(7);
    i_data_idx = hi + 3'(r);
    i_data_valid = !fill && (r < occ) && !m_dk[i_data_idx];
    i_data_value = m_data[i_data_idx];
    i_data_size = m_size[i_data_idx];
    i_commit_valid = !fill && (m_cmt != m_tail) && m_rdy[m_cmt[2:0]] && $urandom_range(1);
    i_pready = ($urandom_range(2) != 0);
    i_ld_valid = $urandom_range(1);
    i_ld_size = mem_access_pkg::mem_size_e'($urandom_range(2));
    i_ld_paddr = rand_addr(i_ld_size);
    i_ld_stq_tail = fill ? m_tail : m_tail - stq_pkg::stq_ptr_t'($urandom_range(3));

    exp_ld = i_ld_valid;
    if (i_ld_valid) predict_load();
    free = o_penable && i_pready;
    exp_pen = o_psel && !free;
    exp_psel = exp_pen || (!o_psel && ncmt != 0) || (free && ncmt >= 2);

    // Model follows the coming rising edge
    if (free) m_head = m_head + 1'b1;
    if (i_commit_valid) m_cmt = m_cmt + 1'b1;
    m_rdy = m_rdy | (m_ak & m_dk);
    if (i_addr_valid) m_ak[i_addr_idx] = 1'b1;
    if (i_data_valid) m_dk[i_data_idx] = 1'b1;
    if (i_disp_valid && occ != 8) begin
      ti = m_tail[2:0];
      m_ak[ti] = 1'b0;
      m_dk[ti] = 1'b0;
      m_rdy[ti] = 1'b0;
      m_size[ti] = mem_access_pkg::mem_size_e'($urandom_range(2));
      m_paddr[ti] = rand_addr(m_size[ti]);
      m_data[ti] = $urandom;
      m_tail = m_tail + 1'b1;
      sent++;
    end
  endtask

  initial begin
    void'($urandom(32'h95f4_d9c5));
    {i_disp_valid, i_addr_valid, i_data_valid, i_commit_valid, i_ld_valid, i_pready} = '0;
    {i_addr_idx, i_data_idx, i_addr_paddr, i_data_value, i_ld_paddr} = '0;
    i_addr_size = mem_access_pkg::SIZE_B;
    i_data_size = mem_access_pkg::SIZE_B;
    i_ld_size = mem_access_pkg::SIZE_B;
    i_ld_stq_tail = '0;
    for (int i = 0; i < 8; i++) begin
      m_paddr[i] = '0;
      m_data[i] = '0;
      m_size[i] = mem_access_pkg::SIZE_B;
    end
    {m_ak, m_dk, m_rdy, m_head, m_tail, m_cmt} = '0;
    {exp_ld, exp_hz, exp_fv, exp_psel, exp_pen, exp_be, exp_data} = '0;
    @(posedge i_reset_n);
    while (!(sent == NUM_STORES && m_head == m_tail)) begin
      @(negedge i_clk);
      step();
    end
    @(negedge i_clk);
    compare_outputs(); // Last free and last load
    $display("Checks: %0d, errors: %0d, cycles: %0d", checks, errors, cycles);
    if (errors == 0) begin
      $display("SIMULATION PASSED");
    end else begin
      $display("SIMULATION FAILED");
    end
    $finish;
  end

  always @(posedge i_clk) begin
    cycles++;
    if (cycles > TIMEOUT_CYCLES) begin
      $display("Timeout: queue not drained after %0d cycles, %0d errors", cycles, errors);
      $display("SIMULATION FAILED");
      $finish;
    end
  end

endmodule
